// ==== src/mem_pkg.sv ====
package mem_pkg;

	////////////////////////////////////////
	// cacheline geometry
	////////////////////////////////////////

	localparam int CACHELINE_SIZE = 128;   // bytes
	localparam int CACHELINE_BITS = 1024;
	localparam int BEAT_BITS      = 512;   // half a line per data beat

	// which vertex array a command or beat belongs to
	typedef enum logic [1:0] {
		TAG_NONE,
		TAG_IN_DEGREE,
		TAG_OUT_DEGREE,
		TAG_EDGES_IDX
	} array_tag_t;

	////////////////////////////////////////
	// read channel
	////////////////////////////////////////

	typedef struct packed {
		logic        valid;
		logic [63:0] address;
		logic [15:0] size;     // power of two, bytes
		array_tag_t  tag;
	} read_command_t;

	typedef struct packed {
		logic           valid;
		array_tag_t     tag;
		logic [511:0]   data;
	} read_data_t;

	// one pulse per line, after both beats
	typedef struct packed {
		logic       valid;
		array_tag_t tag;
	} read_response_t;

endpackage

// ==== src/graph_pkg.sv ====
package graph_pkg;

	////////////////////////////////////////
	// vertex and chunk sizes
	////////////////////////////////////////

	localparam int VERTEX_BITS    = 32;
	localparam int CHUNK_VERTICES = 32;   // one cacheline of 32-bit words

	// work descriptor, held for the whole run
	typedef struct packed {
		logic        valid;
		logic [31:0] num_vertices;
		logic [63:0] in_degree_base;
		logic [63:0] out_degree_base;
		logic [63:0] edges_idx_base;
	} wed_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] id;
		logic [31:0] in_degree;
		logic [31:0] out_degree;
		logic [31:0] edges_idx;
	} vertex_t;

	////////////////////////////////////////
	// vertex buffer status
	////////////////////////////////////////

	typedef struct packed {
		logic valid;    // data_out holds a popped record
		logic empty;
		logic full;
		logic alfull;   // one free slot left
	} buffer_status_t;

endpackage

// ==== src/read_command_gen.sv ====
`timescale 1ns/1ps

module read_command_gen (
	input  logic                    clock,
	input  logic                    rstn,
	input  graph_pkg::wed_t         wed,
	input  mem_pkg::read_response_t read_response,
	input  logic                    buffer_empty,
	output mem_pkg::read_command_t  read_command,
	output logic                    reads_pending
);

	import mem_pkg::*;
	import graph_pkg::*;

	typedef enum logic [2:0] {
		ST_RESET,
		ST_INIT,
		ST_IDLE,
		ST_SIZE,
		ST_IN_DEGREE,
		ST_OUT_DEGREE,
		ST_EDGES_IDX
	} state_t;

	state_t state, next_state;

	logic [31:0] remaining;      // vertices not yet requested
	logic [63:0] chunk_offset;
	logic [15:0] request_size;
	logic [3:0]  outstanding;
	logic        issue;
	logic        send_ready;

	// smallest power of two covering the chunk, capped at one line
	function automatic logic [15:0] request_bytes(input logic [31:0] count);
		logic [15:0] bytes;
		logic [15:0] size;
		bytes = {count[13:0], 2'b00};
		size = 16'd4;
		for (int i = 0; i < 5; i++) begin
			if (size < bytes)
				size = size << 1;
		end
		if (count >= 32'(CHUNK_VERTICES))
			size = 16'(CACHELINE_SIZE);
		return size;
	endfunction

	assign send_ready = buffer_empty && (|remaining) && !reads_pending;
	assign issue = (state == ST_IN_DEGREE) || (state == ST_OUT_DEGREE) ||
		(state == ST_EDGES_IDX);

	////////////////////////////////////////
	// chunk FSM
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			state <= ST_RESET;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			ST_RESET:      if (wed.valid) next_state = ST_INIT;
			ST_INIT:       next_state = ST_IDLE;
			ST_IDLE:       if (send_ready) next_state = ST_SIZE;
			ST_SIZE:       next_state = ST_IN_DEGREE;
			ST_IN_DEGREE:  next_state = ST_OUT_DEGREE;
			ST_OUT_DEGREE: next_state = ST_EDGES_IDX;
			ST_EDGES_IDX:  next_state = ST_IDLE;
			default:       next_state = ST_RESET;
		endcase
	end

	////////////////////////////////////////
	// commands and chunk bookkeeping
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command <= '0;
			remaining    <= '0;
			chunk_offset <= '0;
			request_size <= '0;
		end else begin
			read_command.valid <= 1'b0;   // strobe, one cycle per command
			case (state)
				ST_INIT: remaining <= wed.num_vertices;
				ST_SIZE: begin
					request_size <= request_bytes(remaining);
					if (remaining >= 32'(CHUNK_VERTICES))
						remaining <= remaining - 32'(CHUNK_VERTICES);
					else
						remaining <= '0;
				end
				ST_IN_DEGREE: read_command <= '{valid: 1'b1, address: wed.in_degree_base + chunk_offset,
					size: request_size, tag: TAG_IN_DEGREE};
				ST_OUT_DEGREE: read_command <= '{valid: 1'b1,
					address: wed.out_degree_base + chunk_offset, size: request_size,
					tag: TAG_OUT_DEGREE};
				ST_EDGES_IDX: begin
					read_command <= '{valid: 1'b1, address: wed.edges_idx_base + chunk_offset,
						size: request_size, tag: TAG_EDGES_IDX};
					chunk_offset <= chunk_offset + 64'(CACHELINE_SIZE);   // next line
				end
				default: ;
			endcase
		end
	end

	// counted at issue so a new chunk never sees a stale zero
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			outstanding <= '0;
		else
			outstanding <= outstanding + {3'b000, issue} - {3'b000, read_response.valid};
	end

	assign reads_pending = |outstanding;

endmodule

// ==== src/cacheline_unpacker.sv ====
`timescale 1ns/1ps

module cacheline_unpacker #(
	parameter mem_pkg::array_tag_t TAG = mem_pkg::TAG_IN_DEGREE
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  mem_pkg::read_data_t     read_data,
	input  mem_pkg::read_response_t read_response,
	input  logic                    shift,
	input  logic                    chunk_done,
	output logic                    line_ready,
	output logic [31:0]             head_word
);

	import mem_pkg::*;

	logic [CACHELINE_BITS-1:0] line;
	logic                      beat_odd;   // next beat is beat 1
	logic                      beat_hit;
	logic                      resp_hit;

	// reverse the four bytes of every 32-bit word
	function automatic logic [CACHELINE_BITS-1:0] swap_words(
		input logic [CACHELINE_BITS-1:0] raw
	);
		logic [CACHELINE_BITS-1:0] swapped;
		for (int w = 0; w < CACHELINE_BITS / 32; w++) begin
			for (int b = 0; b < 4; b++) begin
				swapped[w*32 + b*8 +: 8] = raw[w*32 + (3-b)*8 +: 8];
			end
		end
		return swapped;
	endfunction

	assign beat_hit = read_data.valid && (read_data.tag == TAG);
	assign resp_hit = read_response.valid && (read_response.tag == TAG);

	////////////////////////////////////////
	// line register
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (beat_hit) begin
			if (!beat_odd)
				line[CACHELINE_BITS-1 -: BEAT_BITS] <= read_data.data;   // beat 0 on top
			else
				line[BEAT_BITS-1:0] <= read_data.data;
		end else if (resp_hit) begin
			line <= swap_words(line);
		end else if (shift) begin
			line <= line << 32;   // next word to the head
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			beat_odd   <= 1'b0;
			line_ready <= 1'b0;
		end else begin
			if (beat_hit)
				beat_odd <= ~beat_odd;
			if (resp_hit)
				line_ready <= 1'b1;
			else if (chunk_done)
				line_ready <= 1'b0;
		end
	end

	assign head_word = line[CACHELINE_BITS-1 -: 32];

endmodule

// ==== src/vertex_emitter.sv ====
`timescale 1ns/1ps

module vertex_emitter (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic [graph_pkg::VERTEX_BITS-1:0] num_vertices,
	input  logic                              lines_ready,
	input  logic                              reads_pending,
	input  logic [graph_pkg::VERTEX_BITS-1:0] in_degree,
	input  logic [graph_pkg::VERTEX_BITS-1:0] out_degree,
	input  logic [graph_pkg::VERTEX_BITS-1:0] edges_idx,
	output logic                              shift,
	output logic                              chunk_done,
	output graph_pkg::vertex_t                record,
	output logic                              push
);

	import graph_pkg::*;

	logic [VERTEX_BITS-1:0]            vertex_id;   // running id over all chunks
	logic [$clog2(CHUNK_VERTICES):0]   chunk_pos;
	logic                              fill;
	logic                              more;

	assign fill = lines_ready && !reads_pending;
	assign more = (vertex_id < num_vertices) && (32'(chunk_pos) < CHUNK_VERTICES);

	assign shift      = fill && more;
	assign chunk_done = fill && !more;   // releases all three lines

	////////////////////////////////////////
	// record assembly
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_id <= '0;
			chunk_pos <= '0;
			record    <= '0;
		end else begin
			if (shift) begin
				vertex_id <= vertex_id + 1'b1;
				chunk_pos <= chunk_pos + 1'b1;
				record    <= '{valid: 1'b1, id: vertex_id, in_degree: in_degree,
					out_degree: out_degree, edges_idx: edges_idx};
			end else begin
				record.valid <= 1'b0;
			end
			if (chunk_done)
				chunk_pos <= '0;
		end
	end

	// vertices with no neighbours at all are dropped here
	assign push = record.valid && ((|record.in_degree) || (|record.out_degree));

endmodule

// ==== src/vertex_fifo.sv ====
`timescale 1ns/1ps

module vertex_fifo #(
	parameter type T     = logic [31:0],
	parameter int  DEPTH = 32
) (
	input  logic clock,
	input  logic rstn,
	input  logic push,
	input  T     data_in,
	input  logic pop,
	output T     data_out,
	output logic valid,
	output logic empty,
	output logic full,
	output logic alfull
);

	T mem [DEPTH];

	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0]   count;
	logic                     do_push;
	logic                     do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty  = (count == '0);
	assign full   = (32'(count) == DEPTH);
	assign alfull = (32'(count) == DEPTH - 1);

	// storage and registered read port
	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
		if (do_pop)
			data_out <= mem[rd_ptr];
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			valid <= do_pop;   // data_out good one cycle after pop
			if (do_push)
				wr_ptr <= (32'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (32'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

// ==== src/vertex_control.sv ====
`timescale 1ns/1ps

module vertex_control (
	input  logic                      clock,
	input  logic                      rstn,
	input  graph_pkg::wed_t           wed,
	input  mem_pkg::read_data_t       read_data,
	input  mem_pkg::read_response_t   read_response,
	input  logic                      vertex_request,
	output mem_pkg::read_command_t    read_command,
	output graph_pkg::vertex_t        vertex_out,
	output graph_pkg::buffer_status_t buffer_status
);

	import mem_pkg::*;
	import graph_pkg::*;

	logic                   reads_pending;
	logic                   buffer_empty;
	logic                   ready_in, ready_out, ready_edges;
	logic                   lines_ready;
	logic [VERTEX_BITS-1:0] word_in, word_out, word_edges;
	logic                   shift;
	logic                   chunk_done;
	logic                   push;
	vertex_t                record;
	vertex_t                fifo_data;

	assign lines_ready = ready_in && ready_out && ready_edges;

	// no new chunk until the lines are drained and the buffer is empty
	assign buffer_empty = buffer_status.empty && !(ready_in || ready_out || ready_edges);

	read_command_gen read_command_gen_i (
		.clock, .rstn, .wed, .read_response, .buffer_empty, .read_command, .reads_pending
	);

	////////////////////////////////////////
	// one line register per array
	////////////////////////////////////////

	cacheline_unpacker #(.TAG(TAG_IN_DEGREE)) in_degree_line_i (
		.clock, .rstn, .read_data, .read_response, .shift, .chunk_done,
		.line_ready(ready_in), .head_word(word_in)
	);

	cacheline_unpacker #(.TAG(TAG_OUT_DEGREE)) out_degree_line_i (
		.clock, .rstn, .read_data, .read_response, .shift, .chunk_done,
		.line_ready(ready_out), .head_word(word_out)
	);

	cacheline_unpacker #(.TAG(TAG_EDGES_IDX)) edges_idx_line_i (
		.clock, .rstn, .read_data, .read_response, .shift, .chunk_done,
		.line_ready(ready_edges), .head_word(word_edges)
	);

	vertex_emitter vertex_emitter_i (
		.clock, .rstn, .num_vertices(wed.num_vertices), .lines_ready, .reads_pending,
		.in_degree(word_in), .out_degree(word_out), .edges_idx(word_edges),
		.shift, .chunk_done, .record, .push
	);

	vertex_fifo #(.T(vertex_t), .DEPTH(CHUNK_VERTICES)) vertex_buffer_i (
		.clock, .rstn, .push, .data_in(record), .pop(vertex_request),
		.data_out(fifo_data), .valid(buffer_status.valid), .empty(buffer_status.empty),
		.full(buffer_status.full), .alfull(buffer_status.alfull)
	);

	// valid only in the cycle after a pop
	always_comb begin
		vertex_out       = fifo_data;
		vertex_out.valid = buffer_status.valid;
	end

endmodule

// ==== test/tb_graph_model.svh ====
`ifndef TB_GRAPH_MODEL_SVH
`define TB_GRAPH_MODEL_SVH

localparam int NUM_VERTICES = 70;
localparam int NUM_CHUNKS   = (NUM_VERTICES + CHUNK_VERTICES - 1) / CHUNK_VERTICES;
localparam int IMAGE_WORDS  = NUM_CHUNKS * CHUNK_VERTICES;   // whole lines, tail included

localparam logic [63:0] IN_BASE    = 64'h0000_0000_0010_0000;
localparam logic [63:0] OUT_BASE   = 64'h0000_0000_0020_0000;
localparam logic [63:0] EDGES_BASE = 64'h0000_0000_0030_0000;

// raw words as memory holds them, one entry per vertex
logic [31:0] image_in    [IMAGE_WORDS];
logic [31:0] image_out   [IMAGE_WORDS];
logic [31:0] image_edges [IMAGE_WORDS];

read_command_t expect_commands [$];
vertex_t       expect_vertices [$];

function automatic logic [31:0] swap_word(input logic [31:0] w);
	return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// one line for a full chunk, else the next power of two of 4 bytes per vertex
function automatic logic [15:0] expected_size(input int count);
	int bytes;
	bytes = 1;
	if (count >= CHUNK_VERTICES)
		return 16'(CACHELINE_SIZE);
	while (bytes < 4 * count)
		bytes = bytes * 2;
	return 16'(bytes);
endfunction

function automatic logic [63:0] base_of(input array_tag_t tag);
	case (tag)
		TAG_IN_DEGREE:  return IN_BASE;
		TAG_OUT_DEGREE: return OUT_BASE;
		default:        return EDGES_BASE;
	endcase
endfunction

function automatic logic [31:0] image_word(input array_tag_t tag, input int index);
	case (tag)
		TAG_IN_DEGREE:  return image_in[index];
		TAG_OUT_DEGREE: return image_out[index];
		default:        return image_edges[index];
	endcase
endfunction

// beat 0 carries words 0..15 of the line, first word at the top
function automatic logic [BEAT_BITS-1:0] line_beat(input array_tag_t tag, input int first,
	input int half);
	logic [BEAT_BITS-1:0] beat;
	for (int k = 0; k < 16; k++)
		beat[BEAT_BITS-1 - 32*k -: 32] = image_word(tag, first + 16*half + k);
	return beat;
endfunction

task automatic fill_image();
	for (int i = 0; i < IMAGE_WORDS; i++) begin
		image_in[i]    = $random(seed);
		image_out[i]   = $random(seed);
		image_edges[i] = $random(seed);
		if ($unsigned($random(seed)) % 4 == 0) begin   // isolated vertex
			image_in[i]  = '0;
			image_out[i] = '0;
		end
	end
endtask

task automatic build_expected();
	int          remaining;
	logic [63:0] offset;
	logic [15:0] size;
	vertex_t     v;
	remaining = NUM_VERTICES;
	for (int c = 0; c < NUM_CHUNKS; c++) begin
		offset = 64'(c) * 64'(CACHELINE_SIZE);
		size = expected_size(remaining);
		expect_commands.push_back('{valid: 1'b1, address: IN_BASE + offset, size: size,
			tag: TAG_IN_DEGREE});
		expect_commands.push_back('{valid: 1'b1, address: OUT_BASE + offset, size: size,
			tag: TAG_OUT_DEGREE});
		expect_commands.push_back('{valid: 1'b1, address: EDGES_BASE + offset, size: size,
			tag: TAG_EDGES_IDX});
		remaining = remaining - CHUNK_VERTICES;
	end
	for (int id = 0; id < NUM_VERTICES; id++) begin
		v = '{valid: 1'b1, id: 32'(id), in_degree: swap_word(image_in[id]),
			out_degree: swap_word(image_out[id]), edges_idx: swap_word(image_edges[id])};
		if (v.in_degree != '0 || v.out_degree != '0)
			expect_vertices.push_back(v);
	end
endtask

`endif

// ==== test/tb_vertex_control.sv ====
`timescale 1ns/1ps

module tb_vertex_control;

	import mem_pkg::*;
	import graph_pkg::*;

	int seed = 29955;

	`include "tb_graph_model.svh"

	localparam int WATCHDOG_CYCLES = 200 * NUM_CHUNKS + 1000;

	logic           clock;
	logic           rstn;
	wed_t           wed;
	read_data_t     read_data;
	read_response_t read_response;
	logic           vertex_request;
	read_command_t  read_command;
	vertex_t        vertex_out;
	buffer_status_t buffer_status;

	read_command_t command_fifo [$];   // seen by the checker, not yet answered
	int            outstanding = 0;
	int            errors = 0;
	int            popped = 0;
	int            expected_total = 0;
	logic          request_seen = 1'b0;

	vertex_control vertex_control_i (
		.clock, .rstn, .wed, .read_data, .read_response, .vertex_request,
		.read_command, .vertex_out, .buffer_status
	);

	always #4 clock = ~clock;

	task automatic check_command(input read_command_t cmd);
		read_command_t exp;
		if (cmd.tag == TAG_IN_DEGREE) begin   // first command of a chunk
			assert (outstanding == 0 && buffer_status.empty) else begin
				errors++;
				$display("new chunk started at %0t with reads outstanding or buffer not empty",
					$time);
			end
		end
		assert (expect_commands.size() != 0) else begin
			errors++;
			$display("unexpected read command to address %h", cmd.address);
		end
		if (expect_commands.size() != 0) begin
			exp = expect_commands.pop_front();
			assert (cmd == exp) else begin
				errors++;
				$display("CHECK FAILED command: expected %h actual %h", exp, cmd);
			end
		end
		command_fifo.push_back(cmd);
		outstanding++;
	endtask

	task automatic check_vertex(input vertex_t v);
		vertex_t exp;
		assert (expect_vertices.size() != 0) else begin
			errors++;
			$display("vertex %0d popped after all expected vertices", v.id);
		end
		if (expect_vertices.size() != 0) begin
			exp = expect_vertices.pop_front();
			assert (v == exp) else begin
				errors++;
				$display("CHECK FAILED vertex %0d: expected %h actual %h", exp.id, exp, v);
			end
		end
		popped++;
	endtask

	task automatic send_line(input read_command_t cmd);
		int first;
		first = int'((cmd.address - base_of(cmd.tag)) >> 2);
		repeat (1 + $unsigned($random(seed)) % 8) @(posedge clock);
		for (int half = 0; half < 2; half++) begin
			read_data <= '{valid: 1'b1, tag: cmd.tag, data: line_beat(cmd.tag, first, half)};
			@(posedge clock);
		end
		read_data     <= '0;
		read_response <= '{valid: 1'b1, tag: cmd.tag};   // after both beats
		@(posedge clock);
		read_response <= '0;
	endtask

	////////////////////////////////////////
	// memory and consumer
	////////////////////////////////////////

	initial begin : memory_responder
		read_command_t line_cmd [3];
		read_command_t held;
		int            pick;
		read_data     = '0;
		read_response = '0;
		forever begin
			@(posedge clock);
			if (command_fifo.size() >= 3) begin
				for (int i = 0; i < 3; i++)
					line_cmd[i] = command_fifo.pop_front();
				for (int i = 2; i > 0; i--) begin   // shuffle the tag order
					pick = int'($unsigned($random(seed)) % (i + 1));
					held = line_cmd[i];
					line_cmd[i] = line_cmd[pick];
					line_cmd[pick] = held;
				end
				for (int i = 0; i < 3; i++)
					send_line(line_cmd[i]);
			end
		end
	end

	initial begin : consumer
		vertex_request = 1'b0;
		forever begin
			@(posedge clock);
			// at most every other cycle, so a pop never meets an empty buffer
			vertex_request <= !buffer_status.empty && !vertex_request &&
				($unsigned($random(seed)) % 4 != 0);
		end
	end

	////////////////////////////////////////
	// checking
	////////////////////////////////////////

	initial begin : compare
		wait (rstn);
		forever begin
			@(posedge clock);
			if (read_response.valid)
				outstanding--;
			if (read_command.valid)
				check_command(read_command);
			assert (vertex_out.valid == request_seen) else begin
				errors++;
				$display("vertex_out.valid at %0t does not follow the pop one cycle later", $time);
			end
			request_seen = vertex_request;
			if (vertex_out.valid)
				check_vertex(vertex_out);
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("timeout after %0d cycles with %0d of %0d vertices popped, %0d errors",
			WATCHDOG_CYCLES, popped, expected_total, errors);
		$display("TEST FAILED");
		$finish;
	end

	initial begin : main
		buffer_status_t idle_status;
		idle_status = '{valid: 1'b0, empty: 1'b1, full: 1'b0, alfull: 1'b0};
		clock = 1'b0;
		rstn  = 1'b0;
		fill_image();
		build_expected();
		expected_total = expect_vertices.size();
		wed = '{valid: 1'b1, num_vertices: 32'(NUM_VERTICES), in_degree_base: IN_BASE,
			out_degree_base: OUT_BASE, edges_idx_base: EDGES_BASE};
		repeat (10) @(posedge clock);
		rstn <= 1'b1;
		@(posedge clock);
		assert (!read_command.valid && !vertex_out.valid && buffer_status == idle_status)
		else begin
			errors++;
			$display("CHECK FAILED reset state: expected %h actual %h",
				{1'b0, 1'b0, idle_status}, {read_command.valid, vertex_out.valid, buffer_status});
		end
		while (popped < expected_total || expect_commands.size() != 0)
			@(posedge clock);
		repeat (50) @(posedge clock);   // catch stray commands or pops
		$display("errors: %0d, vertices checked: %0d of %0d, commands left: %0d",
			errors, popped, expected_total, expect_commands.size());
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+test
src/mem_pkg.sv
src/graph_pkg.sv
src/read_command_gen.sv
src/cacheline_unpacker.sv
src/vertex_emitter.sv
src/vertex_fifo.sv
src/vertex_control.sv
test/tb_vertex_control.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the vertex fetch testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert \
	--top-module tb_vertex_control \
	-Mdir "$build_dir" \
	-f sources.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/Vtb_vertex_control" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the log decides the result
if grep -q "TEST FAILED" "$log"; then
	exit 1
fi
exit 0
